// File: verilog/fp_pkg.sv
`default_nettype none

package fp_pkg;

	//////////////////////////////
	// sizes
	//////////////////////////////
	localparam int N_ADC      = 8;                  // adc channels
	localparam int W_ADC      = 18;                 // adc sample width
	localparam int W_HB       = 16;                 // host data width
	localparam int W_CHAN     = $clog2(N_ADC);      // channel index in a pipe word
	localparam int FIFO_DEPTH = 64;
	localparam int FIFO_AW    = 6;
	localparam int N_WIRE_IN  = 25;                 // wire-in registers
	localparam int N_TRIG     = 5;                  // trigger words

	//////////////////////////////
	// host address map
	//////////////////////////////
	localparam logic [7:0] ADDR_WIRE_IN_BASE  = 8'h00;
	localparam logic [7:0] ADDR_WIRE_OUT_BASE = 8'h20;   // one per channel
	localparam logic [7:0] ADDR_STATUS        = 8'h28;
	localparam logic [7:0] ADDR_TRIG_BASE     = 8'h40;
	localparam logic [7:0] ADDR_PIPE          = 8'ha3;

	// wire-in offsets
	localparam logic [4:0] OFS_ADC_OS            = 5'h00;
	localparam logic [4:0] OFS_OSF_ACTIVATE      = 5'h01;
	localparam logic [4:0] OFS_OSF_CYCLE_DELAY   = 5'h02;
	localparam logic [4:0] OFS_OSF_OSM           = 5'h03;
	localparam logic [4:0] OFS_OSF_UPDATE_EN     = 5'h04;
	localparam logic [4:0] OFS_PID_LOCK_EN       = 5'h05;
	localparam logic [4:0] OFS_PID_SETPOINT      = 5'h06;
	localparam logic [4:0] OFS_PID_P_COEF        = 5'h07;
	localparam logic [4:0] OFS_PID_I_COEF        = 5'h08;
	localparam logic [4:0] OFS_PID_D_COEF        = 5'h09;
	localparam logic [4:0] OFS_PID_UPDATE_EN     = 5'h0a;
	localparam logic [4:0] OFS_RTR_SRC_SEL       = 5'h0b;
	localparam logic [4:0] OFS_RTR_DEST_SEL      = 5'h0c;
	localparam logic [4:0] OFS_RTR_OUTPUT_ACTIVE = 5'h0d;
	localparam logic [4:0] OFS_OPP_INIT0         = 5'h0e;   // low word, init1/init2 follow
	localparam logic [4:0] OFS_OPP_INIT1         = 5'h0f;
	localparam logic [4:0] OFS_OPP_INIT2         = 5'h10;
	localparam logic [4:0] OFS_OPP_MIN0          = 5'h11;
	localparam logic [4:0] OFS_OPP_MIN1          = 5'h12;
	localparam logic [4:0] OFS_OPP_MIN2          = 5'h13;
	localparam logic [4:0] OFS_OPP_MAX0          = 5'h14;
	localparam logic [4:0] OFS_OPP_MAX1          = 5'h15;
	localparam logic [4:0] OFS_OPP_MAX2          = 5'h16;
	localparam logic [4:0] OFS_OPP_UPDATE_EN     = 5'h17;
	localparam logic [4:0] OFS_OPP_MULTIPLIER    = 5'h18;

	// trigger offsets from ADDR_TRIG_BASE
	localparam logic [4:0] TRIG_ADC_CSTART    = 5'h00;
	localparam logic [4:0] TRIG_PID_CLEAR     = 5'h01;
	localparam logic [4:0] TRIG_DAC_REF_SET   = 5'h02;
	localparam logic [4:0] TRIG_MODULE_UPDATE = 5'h03;
	localparam logic [4:0] TRIG_SYS_RESET     = 5'h04;

	//////////////////////////////
	// types
	//////////////////////////////
	typedef struct packed {
		logic [7:0]      addr;
		logic [W_HB-1:0] wdata;
		logic            write;   // one-cycle strobe
		logic            read;    // one-cycle strobe
	} hb_req_t;

	typedef struct packed {
		logic [2:0]         adc_os;
		logic [N_ADC-1:0]   osf_activate;
		logic [15:0]        osf_cycle_delay;
		logic [5:0]         osf_osm;
		logic [N_ADC-1:0]   osf_update_en;
		logic [N_ADC-1:0]   pid_lock_en;
		logic [15:0]        pid_setpoint;
		logic signed [15:0] pid_p_coef;
		logic signed [15:0] pid_i_coef;
		logic signed [15:0] pid_d_coef;
		logic [N_ADC-1:0]   pid_update_en;
		logic [3:0]         rtr_src_sel;
		logic [3:0]         rtr_dest_sel;
		logic [7:0]         rtr_output_active;
		logic [47:0]        opp_min;
		logic [47:0]        opp_max;
		logic [47:0]        opp_init;
		logic [7:0]         opp_multiplier;
		logic [7:0]         opp_update_en;
	} fp_params_t;

	typedef struct packed {
		logic             adc_cstart;
		logic [N_ADC-1:0] pid_clear;
		logic             dac_ref_set;
		logic             module_update;
		logic             sys_reset;
	} fp_trig_t;

	typedef struct packed {
		logic [W_CHAN-1:0]      chan;
		logic [W_HB-W_CHAN-1:0] sample;   // top bits of the adc sample
	} pipe_word_t;

endpackage

`default_nettype wire

// File: verilog/fp_host_decode.sv
`timescale 1ns/1ps
`default_nettype none

module fp_host_decode (
	input  logic                                          clk50_in,
	input  logic                                          reset,
	input  fp_pkg::hb_req_t                               host,
	input  fp_pkg::fp_params_t                            params,
	input  logic [fp_pkg::N_ADC-1:0][fp_pkg::W_ADC-1:0]   chan_data,
	input  fp_pkg::pipe_word_t                            fifo_head,
	input  logic [fp_pkg::FIFO_AW:0]                      fifo_count,
	input  logic                                          overflow,
	output logic                                          reg_we,
	output logic                                          trig_we,
	output logic [4:0]                                    reg_addr,
	output logic [fp_pkg::W_HB-1:0]                       reg_wdata,
	output logic                                          fifo_pop,
	output logic [fp_pkg::W_HB-1:0]                       host_rdata,
	output logic                                          host_rvalid
);
	import fp_pkg::*;

	logic [7:0]      off_win, off_wo, off_trig;   // base-relative offsets
	logic            is_wire_in, is_wire_out, is_trig, is_status, is_pipe;
	logic [W_HB-1:0] win_rd, rd_mux;

	//////////////////////////////
	// address classify
	//////////////////////////////
	assign off_win  = host.addr - ADDR_WIRE_IN_BASE;
	assign off_wo   = host.addr - ADDR_WIRE_OUT_BASE;
	assign off_trig = host.addr - ADDR_TRIG_BASE;

	assign is_wire_in  = off_win < 8'(N_WIRE_IN);
	assign is_wire_out = off_wo < 8'(N_ADC);
	assign is_trig     = off_trig < 8'(N_TRIG);
	assign is_status   = host.addr == ADDR_STATUS;
	assign is_pipe     = host.addr == ADDR_PIPE;

	// writes go straight to the banks, registered there
	assign reg_we    = host.write & is_wire_in;
	assign trig_we   = host.write & is_trig;
	assign reg_addr  = is_trig ? off_trig[4:0] : off_win[4:0];
	assign reg_wdata = host.wdata;
	assign fifo_pop  = host.read & is_pipe & (fifo_count != '0);   // empty pipe pops nothing

	// wire-in readback, zero extended from field width
	always_comb begin
		win_rd = '0;
		case (off_win[4:0])
			OFS_ADC_OS:            win_rd = W_HB'(params.adc_os);
			OFS_OSF_ACTIVATE:      win_rd = W_HB'(params.osf_activate);
			OFS_OSF_CYCLE_DELAY:   win_rd = params.osf_cycle_delay;
			OFS_OSF_OSM:           win_rd = W_HB'(params.osf_osm);
			OFS_OSF_UPDATE_EN:     win_rd = W_HB'(params.osf_update_en);
			OFS_PID_LOCK_EN:       win_rd = W_HB'(params.pid_lock_en);
			OFS_PID_SETPOINT:      win_rd = params.pid_setpoint;
			OFS_PID_P_COEF:        win_rd = params.pid_p_coef;
			OFS_PID_I_COEF:        win_rd = params.pid_i_coef;
			OFS_PID_D_COEF:        win_rd = params.pid_d_coef;
			OFS_PID_UPDATE_EN:     win_rd = W_HB'(params.pid_update_en);
			OFS_RTR_SRC_SEL:       win_rd = W_HB'(params.rtr_src_sel);
			OFS_RTR_DEST_SEL:      win_rd = W_HB'(params.rtr_dest_sel);
			OFS_RTR_OUTPUT_ACTIVE: win_rd = W_HB'(params.rtr_output_active);
			OFS_OPP_INIT0:         win_rd = params.opp_init[15:0];
			OFS_OPP_INIT1:         win_rd = params.opp_init[31:16];
			OFS_OPP_INIT2:         win_rd = params.opp_init[47:32];
			OFS_OPP_MIN0:          win_rd = params.opp_min[15:0];
			OFS_OPP_MIN1:          win_rd = params.opp_min[31:16];
			OFS_OPP_MIN2:          win_rd = params.opp_min[47:32];
			OFS_OPP_MAX0:          win_rd = params.opp_max[15:0];
			OFS_OPP_MAX1:          win_rd = params.opp_max[31:16];
			OFS_OPP_MAX2:          win_rd = params.opp_max[47:32];
			OFS_OPP_UPDATE_EN:     win_rd = W_HB'(params.opp_update_en);
			OFS_OPP_MULTIPLIER:    win_rd = W_HB'(params.opp_multiplier);
			default:               win_rd = '0;
		endcase
	end

	//////////////////////////////
	// read mux
	//////////////////////////////
	always_comb begin
		rd_mux = '0;   // unmapped reads give zero
		if (is_wire_in)
			rd_mux = win_rd;
		else if (is_wire_out)
			rd_mux = chan_data[off_wo[W_CHAN-1:0]][W_ADC-1 -: W_HB];   // bits 17:2
		else if (is_status)
			rd_mux = {overflow, {(W_HB-FIFO_AW-2){1'b0}}, fifo_count};
		else if (fifo_pop)
			rd_mux = fifo_head;   // head leaves the fifo on the same edge
	end

	always_ff @(posedge clk50_in) begin
		if (reset)
			host_rvalid <= 1'b0;
		else
			host_rvalid <= host.read;   // one cycle after the strobe
	end

	always_ff @(posedge clk50_in) begin
		if (host.read)
			host_rdata <= rd_mux;
	end

endmodule

`default_nettype wire

// File: verilog/fp_param_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fp_param_regs (
	input  logic                     clk50_in,
	input  logic                     reset,
	input  logic                     reg_we,
	input  logic [4:0]               reg_addr,
	input  logic [fp_pkg::W_HB-1:0]  reg_wdata,
	output fp_pkg::fp_params_t       params
);
	import fp_pkg::*;

	logic [N_WIRE_IN-1:0][W_HB-1:0] regs;

	// bits kept per register, rest written as zero
	function automatic logic [W_HB-1:0] field_mask(input logic [4:0] ofs);
		case (ofs)
			OFS_ADC_OS:                        field_mask = 16'h0007;
			OFS_OSF_OSM:                       field_mask = 16'h003f;
			OFS_RTR_SRC_SEL, OFS_RTR_DEST_SEL: field_mask = 16'h000f;
			OFS_OSF_ACTIVATE, OFS_OSF_UPDATE_EN, OFS_PID_LOCK_EN, OFS_PID_UPDATE_EN,
			OFS_RTR_OUTPUT_ACTIVE, OFS_OPP_UPDATE_EN, OFS_OPP_MULTIPLIER:
				field_mask = 16'h00ff;
			default:                           field_mask = 16'hffff;   // full word
		endcase
	endfunction

	always_ff @(posedge clk50_in) begin
		if (reset) begin
			regs                     <= '0;
			regs[OFS_OPP_MULTIPLIER] <= 16'd1;   // unity gain out of reset
		end else if (reg_we) begin
			regs[reg_addr] <= reg_wdata & field_mask(reg_addr);
		end
	end

	//////////////////////////////
	// pack into params
	//////////////////////////////
	always_comb begin
		params.adc_os            = regs[OFS_ADC_OS][2:0];
		params.osf_activate      = regs[OFS_OSF_ACTIVATE][N_ADC-1:0];
		params.osf_cycle_delay   = regs[OFS_OSF_CYCLE_DELAY];
		params.osf_osm           = regs[OFS_OSF_OSM][5:0];
		params.osf_update_en     = regs[OFS_OSF_UPDATE_EN][N_ADC-1:0];
		params.pid_lock_en       = regs[OFS_PID_LOCK_EN][N_ADC-1:0];
		params.pid_setpoint      = regs[OFS_PID_SETPOINT];
		params.pid_p_coef        = regs[OFS_PID_P_COEF];   // two's complement
		params.pid_i_coef        = regs[OFS_PID_I_COEF];
		params.pid_d_coef        = regs[OFS_PID_D_COEF];
		params.pid_update_en     = regs[OFS_PID_UPDATE_EN][N_ADC-1:0];
		params.rtr_src_sel       = regs[OFS_RTR_SRC_SEL][3:0];
		params.rtr_dest_sel      = regs[OFS_RTR_DEST_SEL][3:0];
		params.rtr_output_active = regs[OFS_RTR_OUTPUT_ACTIVE][7:0];
		// 48 bit opp values, word 2 on top
		params.opp_min  = {regs[OFS_OPP_MIN2], regs[OFS_OPP_MIN1], regs[OFS_OPP_MIN0]};
		params.opp_max  = {regs[OFS_OPP_MAX2], regs[OFS_OPP_MAX1], regs[OFS_OPP_MAX0]};
		params.opp_init = {regs[OFS_OPP_INIT2], regs[OFS_OPP_INIT1], regs[OFS_OPP_INIT0]};
		params.opp_multiplier    = regs[OFS_OPP_MULTIPLIER][7:0];
		params.opp_update_en     = regs[OFS_OPP_UPDATE_EN][7:0];
	end

endmodule

`default_nettype wire

// File: verilog/fp_trigger_bank.sv
`timescale 1ns/1ps
`default_nettype none

module fp_trigger_bank (
	input  logic                     clk50_in,
	input  logic                     reset,
	input  logic                     trig_we,
	input  logic [4:0]               reg_addr,
	input  logic [fp_pkg::W_HB-1:0]  reg_wdata,
	output fp_pkg::fp_trig_t         trig
);
	import fp_pkg::*;

	// every bit falls back to zero unless written this cycle
	always_ff @(posedge clk50_in) begin
		trig <= '0;
		if (!reset && trig_we) begin
			case (reg_addr)
				TRIG_ADC_CSTART:    trig.adc_cstart    <= reg_wdata[0];
				TRIG_PID_CLEAR:     trig.pid_clear     <= reg_wdata[N_ADC-1:0];   // per channel
				TRIG_DAC_REF_SET:   trig.dac_ref_set   <= reg_wdata[0];
				TRIG_MODULE_UPDATE: trig.module_update <= reg_wdata[0];
				TRIG_SYS_RESET:     trig.sys_reset     <= reg_wdata[0];   // also flushes the pipe
				default:            trig               <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/adc_capture.sv
`timescale 1ns/1ps
`default_nettype none

module adc_capture (
	input  logic                                         clk50_in,
	input  logic                                         reset,
	input  logic [fp_pkg::N_ADC-1:0]                     adc_data_valid,
	input  logic [fp_pkg::W_ADC-1:0]                     adc_data_a,   // channels 0-3
	input  logic [fp_pkg::W_ADC-1:0]                     adc_data_b,   // channels 4-7
	output logic [fp_pkg::N_ADC-1:0][fp_pkg::W_ADC-1:0]  chan_data
);
	import fp_pkg::*;

	//////////////////////////////
	// holding registers
	//////////////////////////////
	// a and b groups load independently
	always_ff @(posedge clk50_in) begin
		if (reset) begin
			chan_data <= '0;
		end else begin
			for (int n = 0; n < N_ADC; n++) begin
				if (adc_data_valid[n])
					chan_data[n] <= (n < N_ADC/2) ? adc_data_a : adc_data_b;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/pipe_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_arbiter (
	input  logic                     clk50_in,
	input  logic                     reset,
	input  logic                     flush,
	input  logic [fp_pkg::N_ADC-1:0] adc_data_valid,
	input  logic [fp_pkg::W_ADC-1:0] adc_data_a,
	input  logic [fp_pkg::W_ADC-1:0] adc_data_b,
	input  logic [fp_pkg::N_ADC-1:0] activate,
	output logic                     wr_en,
	output fp_pkg::pipe_word_t       wr_word,
	output logic                     hold_drop
);
	import fp_pkg::*;

	logic [N_ADC/2-1:0] sel_a, sel_b;              // active strobes per group
	logic               s_a_vld, s_b_vld, hold_vld;
	pipe_word_t         s_a_word, s_b_word, hold_word;
	logic               out_vld, keep_vld, drop;
	pipe_word_t         out_word, keep_word;

	// lowest strobed channel inside a group
	function automatic logic [W_CHAN-2:0] low_idx(input logic [N_ADC/2-1:0] v);
		low_idx = '0;
		for (int i = N_ADC/2-1; i >= 0; i--) begin
			if (v[i])
				low_idx = (W_CHAN-1)'(i);
		end
	endfunction

	assign sel_a = adc_data_valid[N_ADC/2-1:0] & activate[N_ADC/2-1:0];
	assign sel_b = adc_data_valid[N_ADC-1:N_ADC/2] & activate[N_ADC-1:N_ADC/2];

	//////////////////////////////
	// held, then a, then b
	//////////////////////////////
	assign out_vld   = hold_vld | s_a_vld | s_b_vld;
	assign out_word  = hold_vld ? hold_word : (s_a_vld ? s_a_word : s_b_word);
	assign keep_vld  = hold_vld ? (s_a_vld | s_b_vld) : (s_a_vld & s_b_vld);   // second in line
	assign keep_word = (hold_vld & s_a_vld) ? s_a_word : s_b_word;
	assign drop      = hold_vld & s_a_vld & s_b_vld;   // third word has nowhere to go

	always_ff @(posedge clk50_in) begin
		if (reset || flush) begin
			s_a_vld   <= 1'b0;
			s_b_vld   <= 1'b0;
			hold_vld  <= 1'b0;
			wr_en     <= 1'b0;
			hold_drop <= 1'b0;
		end else begin
			s_a_vld   <= |sel_a;
			s_b_vld   <= |sel_b;
			hold_vld  <= keep_vld;
			wr_en     <= out_vld;   // two cycles after the strobe
			hold_drop <= drop;
		end
	end

	// payload stage
	always_ff @(posedge clk50_in) begin
		s_a_word.chan   <= {1'b0, low_idx(sel_a)};
		s_a_word.sample <= adc_data_a[W_ADC-1 -: W_HB-W_CHAN];
		s_b_word.chan   <= {1'b1, low_idx(sel_b)};   // upper half of the channels
		s_b_word.sample <= adc_data_b[W_ADC-1 -: W_HB-W_CHAN];
		hold_word       <= keep_word;
		wr_word         <= out_word;
	end

endmodule

`default_nettype wire

// File: verilog/pipe_tx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_tx_fifo (
	input  logic                      clk50_in,
	input  logic                      reset,
	input  logic                      flush,
	input  logic                      wr_en,
	input  fp_pkg::pipe_word_t        wr_word,
	input  logic                      hold_drop,
	input  logic                      pop,
	output fp_pkg::pipe_word_t        head,
	output logic [fp_pkg::FIFO_AW:0]  count,
	output logic                      overflow
);
	import fp_pkg::*;

	pipe_word_t         mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wptr, rptr;
	logic               do_push, do_pop;

	assign do_push = wr_en & (count != (FIFO_AW+1)'(FIFO_DEPTH));   // full drops the word
	assign do_pop  = pop & (count != '0);

	//////////////////////////////
	// pointers and flags
	//////////////////////////////
	always_ff @(posedge clk50_in) begin
		if (reset || flush) begin
			wptr     <= '0;
			rptr     <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push)
				wptr <= wptr + 1'b1;   // wraps at depth
			if (do_pop)
				rptr <= rptr + 1'b1;
			count <= count + (FIFO_AW+1)'(do_push) - (FIFO_AW+1)'(do_pop);
			if ((wr_en && !do_push) || hold_drop)
				overflow <= 1'b1;   // sticky until flush
		end
	end

	always_ff @(posedge clk50_in) begin
		if (do_push)
			mem[wptr] <= wr_word;
	end

	assign head = mem[rptr];   // show-ahead

endmodule

`default_nettype wire

// File: verilog/frontpanel_interface.sv
`timescale 1ns/1ps
`default_nettype none

module frontpanel_interface (
	input  logic                     clk50_in,
	input  logic                     reset,
	input  fp_pkg::hb_req_t          host,
	input  logic [fp_pkg::N_ADC-1:0] adc_data_valid,
	input  logic [fp_pkg::W_ADC-1:0] adc_data_a,
	input  logic [fp_pkg::W_ADC-1:0] adc_data_b,
	output logic [fp_pkg::W_HB-1:0]  host_rdata,
	output logic                     host_rvalid,
	output fp_pkg::fp_params_t       params,
	output fp_pkg::fp_trig_t         trig
);
	import fp_pkg::*;

	//////////////////////////////
	// internal nets
	//////////////////////////////
	logic                         reg_we, trig_we, fifo_pop;
	logic [4:0]                   reg_addr;
	logic [W_HB-1:0]              reg_wdata;
	logic [N_ADC-1:0][W_ADC-1:0]  chan_data;     // wire-out readbacks
	pipe_word_t                   fifo_head, wr_word;
	logic [FIFO_AW:0]             fifo_count;
	logic                         overflow, wr_en, hold_drop;

	fp_host_decode fp_host_decode_i (
		.clk50_in    (clk50_in),
		.reset       (reset),
		.host        (host),
		.params      (params),
		.chan_data   (chan_data),
		.fifo_head   (fifo_head),
		.fifo_count  (fifo_count),
		.overflow    (overflow),
		.reg_we      (reg_we),
		.trig_we     (trig_we),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.fifo_pop    (fifo_pop),
		.host_rdata  (host_rdata),
		.host_rvalid (host_rvalid)
	);

	fp_param_regs fp_param_regs_i (
		.clk50_in  (clk50_in),
		.reset     (reset),
		.reg_we    (reg_we),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.params    (params)
	);

	fp_trigger_bank fp_trigger_bank_i (
		.clk50_in  (clk50_in),
		.reset     (reset),
		.trig_we   (trig_we),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.trig      (trig)
	);

	adc_capture adc_capture_i (
		.clk50_in       (clk50_in),
		.reset          (reset),
		.adc_data_valid (adc_data_valid),
		.adc_data_a     (adc_data_a),
		.adc_data_b     (adc_data_b),
		.chan_data      (chan_data)
	);

	// osf_activate picks which channels reach the pipe
	pipe_arbiter pipe_arbiter_i (
		.clk50_in       (clk50_in),
		.reset          (reset),
		.flush          (trig.sys_reset),
		.adc_data_valid (adc_data_valid),
		.adc_data_a     (adc_data_a),
		.adc_data_b     (adc_data_b),
		.activate       (params.osf_activate),
		.wr_en          (wr_en),
		.wr_word        (wr_word),
		.hold_drop      (hold_drop)
	);

	pipe_tx_fifo pipe_tx_fifo_i (
		.clk50_in  (clk50_in),
		.reset     (reset),
		.flush     (trig.sys_reset),   // sys_reset empties the pipe
		.wr_en     (wr_en),
		.wr_word   (wr_word),
		.hold_drop (hold_drop),
		.pop       (fifo_pop),
		.head      (fifo_head),
		.count     (fifo_count),
		.overflow  (overflow)
	);

endmodule

`default_nettype wire

// File: verification/frontpanel_interface_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frontpanel_interface_tb;
	import fp_pkg::*;

	localparam int N_OPS = 800;   // rough count of host ops and strobe rounds

	logic        clk50_in = 1'b0;
	logic        reset;
	hb_req_t     host;
	logic [7:0]  adc_data_valid;
	logic [17:0] adc_data_a, adc_data_b;
	logic [15:0] host_rdata;
	logic        host_rvalid;
	fp_params_t  params;
	fp_trig_t    trig;

	logic [31:0] seed = 32'h83da;
	int          value_errs = 0;
	int          other_errs = 0;
	logic [15:0] regs_m [N_WIRE_IN];   // register image
	logic [17:0] chan_m [N_ADC];       // latest sample per channel
	pipe_word_t  pipe_q [$];           // expected pipe contents
	logic        ovf_m = 1'b0;

	frontpanel_interface frontpanel_interface_i (
		.clk50_in       (clk50_in),
		.reset          (reset),
		.host           (host),
		.adc_data_valid (adc_data_valid),
		.adc_data_a     (adc_data_a),
		.adc_data_b     (adc_data_b),
		.host_rdata     (host_rdata),
		.host_rvalid    (host_rvalid),
		.params         (params),
		.trig           (trig)
	);

	always #4 clk50_in = ~clk50_in;   // 125 MHz sim clock

	// watchdog
	initial begin
		repeat (N_OPS * 20 + 2000) @(posedge clk50_in);
		$display("watchdog expired, the test sequence did not finish");
		$display("*** FAILED ***");
		$finish;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	function automatic logic [31:0] next_rand();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	// kept bits per wire-in register
	function automatic logic [15:0] wire_in_mask(input logic [4:0] ofs);
		int          w;
		logic [16:0] m;
		case (ofs)
			OFS_ADC_OS:                        w = 3;
			OFS_OSF_OSM:                       w = 6;
			OFS_RTR_SRC_SEL, OFS_RTR_DEST_SEL: w = 4;
			OFS_OSF_ACTIVATE, OFS_OSF_UPDATE_EN, OFS_PID_LOCK_EN, OFS_PID_UPDATE_EN,
			OFS_RTR_OUTPUT_ACTIVE, OFS_OPP_UPDATE_EN, OFS_OPP_MULTIPLIER:
				w = 8;
			default:                           w = 16;
		endcase
		m = (17'h1 << w) - 17'h1;
		return m[15:0];
	endfunction

	function automatic fp_params_t expected_params();
		fp_params_t p;
		p.adc_os            = regs_m[OFS_ADC_OS][2:0];
		p.osf_activate      = regs_m[OFS_OSF_ACTIVATE][7:0];
		p.osf_cycle_delay   = regs_m[OFS_OSF_CYCLE_DELAY];
		p.osf_osm           = regs_m[OFS_OSF_OSM][5:0];
		p.osf_update_en     = regs_m[OFS_OSF_UPDATE_EN][7:0];
		p.pid_lock_en       = regs_m[OFS_PID_LOCK_EN][7:0];
		p.pid_setpoint      = regs_m[OFS_PID_SETPOINT];
		p.pid_p_coef        = regs_m[OFS_PID_P_COEF];
		p.pid_i_coef        = regs_m[OFS_PID_I_COEF];
		p.pid_d_coef        = regs_m[OFS_PID_D_COEF];
		p.pid_update_en     = regs_m[OFS_PID_UPDATE_EN][7:0];
		p.rtr_src_sel       = regs_m[OFS_RTR_SRC_SEL][3:0];
		p.rtr_dest_sel      = regs_m[OFS_RTR_DEST_SEL][3:0];
		p.rtr_output_active = regs_m[OFS_RTR_OUTPUT_ACTIVE][7:0];
		p.opp_min  = {regs_m[OFS_OPP_MIN2], regs_m[OFS_OPP_MIN1], regs_m[OFS_OPP_MIN0]};
		p.opp_max  = {regs_m[OFS_OPP_MAX2], regs_m[OFS_OPP_MAX1], regs_m[OFS_OPP_MAX0]};
		p.opp_init = {regs_m[OFS_OPP_INIT2], regs_m[OFS_OPP_INIT1], regs_m[OFS_OPP_INIT0]};
		p.opp_multiplier    = regs_m[OFS_OPP_MULTIPLIER][7:0];
		p.opp_update_en     = regs_m[OFS_OPP_UPDATE_EN][7:0];
		return p;
	endfunction

	task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_params();
		fp_params_t e;
		e = expected_params();
		if (params !== e) begin
			value_errs++;
			$display("[FAIL] params: got %h, expected %h", params, e);
		end
	endtask

	// write strobe, returns at the negedge of the cycle after it
	task automatic host_write(input logic [7:0] a, input logic [15:0] d);
		@(posedge clk50_in);
		host.addr  <= a;
		host.wdata <= d;
		host.write <= 1'b1;
		@(posedge clk50_in);
		host.write <= 1'b0;
		@(negedge clk50_in);
	endtask

	task automatic host_read(input logic [7:0] a, output logic [15:0] d);
		@(posedge clk50_in);
		host.addr <= a;
		host.read <= 1'b1;
		@(posedge clk50_in);
		host.read <= 1'b0;
		@(negedge clk50_in);
		if (host_rvalid !== 1'b1) begin
			other_errs++;
			$display("read of address %h gave no host_rvalid in the cycle after", a);
		end
		d = host_rdata;
		@(negedge clk50_in);
		if (host_rvalid !== 1'b0) begin
			other_errs++;
			$display("host_rvalid stayed high for more than one cycle");
		end
	endtask

	task automatic read_expect(input string name, input logic [7:0] a, input logic [15:0] exp);
		logic [15:0] d;
		host_read(a, d);
		check_hex(name, 32'(d), 32'(exp));
	endtask

	task automatic wire_in_write(input logic [4:0] ofs, input logic [15:0] d);
		regs_m[ofs] = d & wire_in_mask(ofs);
		host_write(ADDR_WIRE_IN_BASE + 8'(ofs), d);
		check_params();
	endtask

	// trigger write, one-cycle pulse then zero
	task automatic trig_write(input logic [4:0] ofs, input logic [15:0] d);
		fp_trig_t e;
		e = '0;
		case (ofs)
			TRIG_ADC_CSTART:    e.adc_cstart    = d[0];
			TRIG_PID_CLEAR:     e.pid_clear     = d[7:0];
			TRIG_DAC_REF_SET:   e.dac_ref_set   = d[0];
			TRIG_MODULE_UPDATE: e.module_update = d[0];
			default:            e.sys_reset     = d[0];
		endcase
		if (e.sys_reset) begin
			pipe_q.delete();   // flush empties the pipe
			ovf_m = 1'b0;
		end
		host_write(ADDR_TRIG_BASE + 8'(ofs), d);
		check_hex("trig", 32'(trig), 32'(e));
		@(negedge clk50_in);
		check_hex("trig", 32'(trig), 32'h0);
	endtask

	// one strobe round, idle cycle after it keeps per-group spacing
	task automatic strobe_round(input int pick_a, input int pick_b);
		logic [7:0]  v;
		logic [17:0] da, db;
		da = 18'(next_rand());
		db = 18'(next_rand());
		v  = '0;
		if (pick_a < 4) begin
			v[pick_a] = 1'b1;
			chan_m[pick_a] = da;
			if (regs_m[OFS_OSF_ACTIVATE][pick_a])
				pipe_q.push_back({3'(pick_a), da[17:5]});   // a before b
		end
		if (pick_b < 4) begin
			v[pick_b + 4] = 1'b1;
			chan_m[pick_b + 4] = db;
			if (regs_m[OFS_OSF_ACTIVATE][pick_b + 4])
				pipe_q.push_back({3'(pick_b + 4), db[17:5]});
		end
		@(posedge clk50_in);
		adc_data_valid <= v;
		adc_data_a     <= da;
		adc_data_b     <= db;
		@(posedge clk50_in);
		adc_data_valid <= '0;
	endtask

	function automatic logic [15:0] status_word(input int cnt);
		return {ovf_m, 8'h00, 7'(cnt)};
	endfunction

	//////////////////////////////
	// test sequence
	//////////////////////////////
	initial begin
		logic [4:0]  ofs;
		logic [15:0] d;
		int          n;
		host           = '0;
		adc_data_valid = '0;
		adc_data_a     = '0;
		adc_data_b     = '0;
		reset          = 1'b1;
		for (int i = 0; i < N_WIRE_IN; i++)
			regs_m[i] = '0;
		regs_m[OFS_OPP_MULTIPLIER] = 16'd1;
		for (int i = 0; i < N_ADC; i++)
			chan_m[i] = '0;
		repeat (16) @(posedge clk50_in);
		reset <= 1'b0;
		@(negedge clk50_in);

		// reset values
		check_params();
		check_hex("trig", 32'(trig), 32'h0);
		check_hex("host_rvalid", 32'(host_rvalid), 32'h0);
		read_expect("status", ADDR_STATUS, 16'h0000);
		for (int i = 0; i < N_ADC; i++)
			read_expect("wire-out", ADDR_WIRE_OUT_BASE + 8'(i), 16'h0000);

		// wire-in writes and readback
		for (int i = 0; i < 200; i++) begin
			ofs = 5'(next_rand() % N_WIRE_IN);
			d   = 16'(next_rand());
			wire_in_write(ofs, d);
			read_expect("wire-in readback", ADDR_WIRE_IN_BASE + 8'(ofs), regs_m[ofs]);
		end
		read_expect("unmapped read", 8'h30, 16'h0000);

		// triggers
		for (int t = 0; t < N_TRIG; t++)
			trig_write(5'(t), 16'(next_rand()));
		trig_write(TRIG_SYS_RESET, 16'h0001);

		// channel readback, pipe kept quiet
		wire_in_write(OFS_OSF_ACTIVATE, 16'h0000);
		for (int i = 0; i < 40; i++) begin
			strobe_round(int'(next_rand() % 5), int'(next_rand() % 5));
			n = int'(next_rand() % N_ADC);
			read_expect("wire-out", ADDR_WIRE_OUT_BASE + 8'(n), chan_m[n][17:2]);
		end
		for (int i = 0; i < N_ADC; i++)
			read_expect("wire-out", ADDR_WIRE_OUT_BASE + 8'(i), chan_m[i][17:2]);

		// pipe contents in arrival order
		wire_in_write(OFS_OSF_ACTIVATE, 16'(next_rand()) | 16'h0011);
		for (int i = 0; i < 24; i++)
			strobe_round(int'(next_rand() % 5), int'(next_rand() % 5));
		repeat (6) @(posedge clk50_in);
		read_expect("status", ADDR_STATUS, status_word(pipe_q.size()));
		n = pipe_q.size();
		for (int i = 0; i < n; i++)
			read_expect("pipe word", ADDR_PIPE, pipe_q.pop_front());
		read_expect("empty pipe", ADDR_PIPE, 16'h0000);
		read_expect("status", ADDR_STATUS, status_word(0));

		// overflow then flush
		wire_in_write(OFS_OSF_ACTIVATE, 16'h0001);
		for (int i = 0; i < 80; i++)
			strobe_round(0, 4);
		repeat (6) @(posedge clk50_in);
		ovf_m = 1'b1;
		read_expect("status", ADDR_STATUS, status_word(FIFO_DEPTH));
		trig_write(TRIG_SYS_RESET, 16'h0001);
		read_expect("status", ADDR_STATUS, status_word(0));

		$display("error counts: %0d value, %0d other", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
verilog/fp_pkg.sv
verilog/fp_host_decode.sv
verilog/fp_param_regs.sv
verilog/fp_trigger_bank.sv
verilog/adc_capture.sv
verilog/pipe_arbiter.sv
verilog/pipe_tx_fifo.sv
verilog/frontpanel_interface.sv
verification/frontpanel_interface_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f all.f --top-module frontpanel_interface_tb \
	-o frontpanel_interface_sim &&
	./obj_dir/frontpanel_interface_sim | tee /dev/stderr | grep -qF '*** PASSED ***' &&
	echo "simulation passed" && exit 0 ||
	{ echo "simulation failed"; exit 1; }
